/* design/controlUnit_params.svh */
`ifndef CONTROLUNIT_PARAMS_SVH
`define CONTROLUNIT_PARAMS_SVH

// Instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6

// Control select widths
`define SEL2_WIDTH 2
`define SEL3_WIDTH 3

// Opcodes handled by the decoder
`define OPC_RTYPE 6'h00
`define OPC_ADDI 6'h08

// R-format funct codes
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03

`endif

/* design/controlPkg.sv */
`include "controlUnit_params.svh"

package controlPkg;

    // Instruction fields
    typedef logic [`OPCODE_WIDTH-1:0] opcodeT;
    typedef logic [`FUNCT_WIDTH-1:0] functT;

    // Control selects
    typedef logic [`SEL2_WIDTH-1:0] sel2T;
    typedef logic [`SEL3_WIDTH-1:0] sel3T;

    typedef enum logic [2:0] {
        classAdd,
        classSub,
        classAnd,
        classSll,
        classSrl,
        classSra,
        classAddi,
        classInvalid
    } instrClassT;

    typedef enum logic [5:0] {
        // Common front end
        stFetch,
        stWait,
        stWait2,
        stDecode,
        stDecodeWait,
        // Register ALU operations
        stAdd,
        stSub,
        stAnd,
        stEndAlu,
        // Shifts by shamt
        stShiftShamt,
        stSll,
        stSrl,
        stSra,
        stShiftWait,
        stEndShift,
        // Immediate add
        stAddi,
        stEndImm,
        // Every instruction ends here
        stDelay
    } ctrlStateT;

endpackage

/* design/instrDecoder.sv */
`include "controlUnit_params.svh"

module instrDecoder (
    input  controlPkg::opcodeT     opcode,
    input  controlPkg::functT      funct,
    output controlPkg::instrClassT instrClass
);
    import controlPkg::*;

    instrClassT rClass;

    // R-format instructions are told apart by funct
    always_comb begin
        case (funct)
            `FN_ADD: begin
                rClass = classAdd;
            end
            `FN_SUB: begin
                rClass = classSub;
            end
            `FN_AND: begin
                rClass = classAnd;
            end
            `FN_SLL: begin
                rClass = classSll;
            end
            `FN_SRL: begin
                rClass = classSrl;
            end
            `FN_SRA: begin
                rClass = classSra;
            end
            default: begin
                rClass = classInvalid;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            `OPC_RTYPE: begin
                instrClass = rClass;
            end
            `OPC_ADDI: begin
                instrClass = classAddi;
            end
            default: begin
                instrClass = classInvalid;
            end
        endcase
    end

endmodule

/* design/stateSequencer.sv */
module stateSequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    output controlPkg::ctrlStateT  state
);
    import controlPkg::*;

    ctrlStateT  nextState;
    instrClassT heldClass;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    // Class seen in decode-wait, kept for the shift branch
    always_ff @(posedge clk) begin
        if (reset) begin
            heldClass <= classInvalid;
        end else if (state == stDecodeWait) begin
            heldClass <= instrClass;
        end
    end

    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch:      nextState = stWait;
            stWait:       nextState = stWait2;
            stWait2:      nextState = stDecode;
            stDecode:     nextState = stDecodeWait;
            stDecodeWait: begin
                case (instrClass)
                    classAdd: begin
                        nextState = stAdd;
                    end
                    classSub: begin
                        nextState = stSub;
                    end
                    classAnd: begin
                        nextState = stAnd;
                    end
                    classSll, classSrl, classSra: begin
                        nextState = stShiftShamt;
                    end
                    classAddi: begin
                        nextState = stAddi;
                    end
                    // Unsupported encodings retire through the delay state
                    default: begin
                        nextState = stDelay;
                    end
                endcase
            end
            stAdd, stSub, stAnd: nextState = stEndAlu;
            stEndAlu:            nextState = stDelay;
            stShiftShamt: begin
                case (heldClass)
                    classSll: begin
                        nextState = stSll;
                    end
                    classSrl: begin
                        nextState = stSrl;
                    end
                    classSra: begin
                        nextState = stSra;
                    end
                    default: begin
                        nextState = stDelay;
                    end
                endcase
            end
            stSll, stSrl, stSra: nextState = stShiftWait;
            stShiftWait:         nextState = stEndShift;
            stEndShift:          nextState = stDelay;
            stAddi:              nextState = stEndImm;
            stEndImm:            nextState = stDelay;
            stDelay:             nextState = stFetch;
            default:             nextState = stFetch;
        endcase
    end

endmodule

/* design/controlEncoder.sv */
module controlEncoder (
    input  logic                  clk,
    input  logic                  reset,
    input  controlPkg::ctrlStateT state,
    output logic                  pcWrite,
    output logic                  irWrite,
    output logic                  regWrite,
    output logic                  aWrite,
    output logic                  bWrite,
    output logic                  aluOutWrite,
    output logic                  shiftSrc,
    output controlPkg::sel2T      regDst,
    output controlPkg::sel2T      aluSrcA,
    output controlPkg::sel3T      aluSrcB,
    output controlPkg::sel3T      aluOp,
    output controlPkg::sel3T      memToReg,
    output controlPkg::sel3T      shiftCtrl
);
    import controlPkg::*;

    logic nextPcWrite;
    logic nextIrWrite;
    logic nextRegWrite;
    logic nextAWrite;
    logic nextBWrite;
    logic nextAluOutWrite;
    logic nextShiftSrc;
    sel2T nextRegDst;
    sel2T nextAluSrcA;
    sel3T nextAluSrcB;
    sel3T nextAluOp;
    sel3T nextMemToReg;
    sel3T nextShiftCtrl;

    // Control word of the current state, zero unless set below
    always_comb begin
        nextPcWrite     = 1'b0;
        nextIrWrite     = 1'b0;
        nextRegWrite    = 1'b0;
        nextAWrite      = 1'b0;
        nextBWrite      = 1'b0;
        nextAluOutWrite = 1'b0;
        nextShiftSrc    = 1'b0;
        nextRegDst      = '0;
        nextAluSrcA     = '0;
        nextAluSrcB     = '0;
        nextAluOp       = '0;
        nextMemToReg    = '0;
        nextShiftCtrl   = '0;
        case (state)
            stFetch: begin
                nextAluSrcB = 3'd1;
                nextAluOp   = 3'd1;
            end
            stWait: begin
                nextPcWrite = 1'b1;
                nextAluSrcB = 3'd1;
                nextAluOp   = 3'd1;
            end
            stWait2: begin
                nextIrWrite = 1'b1;
                nextAluSrcB = 3'd1;
            end
            stDecode: begin
                nextAWrite      = 1'b1;
                nextBWrite      = 1'b1;
                nextAluOutWrite = 1'b1;
                nextAluSrcB     = 3'd4;
                nextAluOp       = 3'd1;
            end
            stDecodeWait: begin
                nextAluOp = 3'd1;
            end
            stAdd, stSub, stAnd: begin
                nextAluOutWrite = 1'b1;
                nextAluSrcA     = 2'd1;
                // aluOp 1, 2, 3 for add, sub, and
                if (state == stAdd) begin
                    nextAluOp = 3'd1;
                end else if (state == stSub) begin
                    nextAluOp = 3'd2;
                end else begin
                    nextAluOp = 3'd3;
                end
            end
            stEndAlu: begin
                nextRegWrite = 1'b1;
                nextRegDst   = 2'd3;
            end
            stShiftShamt: begin
                nextShiftSrc  = 1'b1;
                nextShiftCtrl = 3'd1;
            end
            stSll: begin
                nextShiftSrc  = 1'b1;
                nextShiftCtrl = 3'd2;
            end
            stSrl: begin
                nextShiftCtrl = 3'd3;
            end
            stSra: begin
                nextShiftCtrl = 3'd4;
            end
            stEndShift: begin
                nextRegWrite = 1'b1;
                nextRegDst   = 2'd3;
                nextMemToReg = 3'd2;
            end
            stAddi: begin
                nextAluOutWrite = 1'b1;
                nextAluSrcA     = 2'd1;
                nextAluSrcB     = 3'd3;
                nextAluOp       = 3'd1;
            end
            stEndImm: begin
                nextRegWrite = 1'b1;
            end
            // Shift wait and delay drive an all-zero word
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            aWrite      <= 1'b0;
            bWrite      <= 1'b0;
            aluOutWrite <= 1'b0;
            shiftSrc    <= 1'b0;
            regDst      <= '0;
            aluSrcA     <= '0;
            aluSrcB     <= '0;
            aluOp       <= '0;
            memToReg    <= '0;
            shiftCtrl   <= '0;
        end else begin
            pcWrite     <= nextPcWrite;
            irWrite     <= nextIrWrite;
            regWrite    <= nextRegWrite;
            aWrite      <= nextAWrite;
            bWrite      <= nextBWrite;
            aluOutWrite <= nextAluOutWrite;
            shiftSrc    <= nextShiftSrc;
            regDst      <= nextRegDst;
            aluSrcA     <= nextAluSrcA;
            aluSrcB     <= nextAluSrcB;
            aluOp       <= nextAluOp;
            memToReg    <= nextMemToReg;
            shiftCtrl   <= nextShiftCtrl;
        end
    end

endmodule

/* design/controlUnit.sv */
module controlUnit (
    input  logic                clk,
    input  logic                reset,
    input  controlPkg::opcodeT  opcode,
    input  controlPkg::functT   funct,
    output logic                pcWrite,
    output logic                irWrite,
    output logic                regWrite,
    output logic                aWrite,
    output logic                bWrite,
    output logic                aluOutWrite,
    output logic                shiftSrc,
    output controlPkg::sel2T    regDst,
    output controlPkg::sel2T    aluSrcA,
    output controlPkg::sel3T    aluSrcB,
    output controlPkg::sel3T    aluOp,
    output controlPkg::sel3T    memToReg,
    output controlPkg::sel3T    shiftCtrl
);
    import controlPkg::*;

    instrClassT instrClass;
    ctrlStateT  state;

    // Opcode and funct held by the instruction register outside
    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    stateSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state)
    );

    // Outputs lag the state by one cycle
    controlEncoder encoder (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .shiftSrc    (shiftSrc),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .memToReg    (memToReg),
        .shiftCtrl   (shiftCtrl)
    );

endmodule

/* testbench/controlUnit_sva.sv */
module controlUnitAssertions (
    input logic             clk,
    input logic             reset,
    input logic             pcWrite,
    input logic             irWrite,
    input logic             regWrite,
    input logic             aluOutWrite,
    input controlPkg::sel3T shiftCtrl
);
    logic       irSeen;
    logic [3:0] pcPulses;

    // pcWrite pulses since the last irWrite
    always_ff @(posedge clk) begin
        if (reset) begin
            irSeen   <= 1'b0;
            pcPulses <= '0;
        end else if (irWrite) begin
            irSeen   <= 1'b1;
            pcPulses <= '0;
        end else if (pcWrite) begin
            pcPulses <= pcPulses + 4'd1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (irWrite && irSeen) |-> (pcPulses == 4'd1))
        else $error("pcWrite did not pulse exactly once between two irWrite pulses");

    assert property (@(posedge clk) disable iff (reset)
        regWrite |-> !(aluOutWrite || irWrite))
        else $error("regWrite is high together with aluOutWrite or irWrite");

    assert property (@(posedge clk) disable iff (reset)
        (shiftCtrl != 3'd0) |-> !regWrite)
        else $error("shiftCtrl is nonzero while regWrite is high");

endmodule

bind controlUnit controlUnitAssertions assertions (
    .clk         (clk),
    .reset       (reset),
    .pcWrite     (pcWrite),
    .irWrite     (irWrite),
    .regWrite    (regWrite),
    .aluOutWrite (aluOutWrite),
    .shiftCtrl   (shiftCtrl)
);

/* testbench/controlUnitTb.sv */
`include "controlUnit_params.svh"

module controlUnitTb;

    localparam int numInstr = 300;
    localparam int cycleLimit = 12 * numInstr + 100;

    // Instruction kinds picked by the stimulus
    localparam int kindAdd = 0;
    localparam int kindSub = 1;
    localparam int kindAnd = 2;
    localparam int kindSll = 3;
    localparam int kindSrl = 4;
    localparam int kindSra = 5;
    localparam int kindAddi = 6;
    localparam int kindInvalid = 7;

    typedef struct packed {
        logic       pcWrite;
        logic       irWrite;
        logic       regWrite;
        logic       aWrite;
        logic       bWrite;
        logic       aluOutWrite;
        logic       shiftSrc;
        logic [1:0] regDst;
        logic [1:0] aluSrcA;
        logic [2:0] aluSrcB;
        logic [2:0] aluOp;
        logic [2:0] memToReg;
        logic [2:0] shiftCtrl;
    } ctrlWordT;

    logic                     clk;
    logic                     reset;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`FUNCT_WIDTH-1:0]  funct;
    logic                     pcWrite;
    logic                     irWrite;
    logic                     regWrite;
    logic                     aWrite;
    logic                     bWrite;
    logic                     aluOutWrite;
    logic                     shiftSrc;
    logic [`SEL2_WIDTH-1:0]   regDst;
    logic [`SEL2_WIDTH-1:0]   aluSrcA;
    logic [`SEL3_WIDTH-1:0]   aluSrcB;
    logic [`SEL3_WIDTH-1:0]   aluOp;
    logic [`SEL3_WIDTH-1:0]   memToReg;
    logic [`SEL3_WIDTH-1:0]   shiftCtrl;

    logic [31:0] randState;
    ctrlWordT    expWord;
    int          modelStep;
    int          currentKind;
    int          cycleCount;
    int          valueErrors;
    int          lengthErrors;
    int          issued;
    int          invalidCount;
    int          cyclesSinceIr;
    bit          done;

    controlUnit uut (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .shiftSrc    (shiftSrc),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .memToReg    (memToReg),
        .shiftCtrl   (shiftCtrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        randState = randState * 32'd1664525 + 32'd1013904223;
        return randState;
    endfunction

    // Arguments follow the port order of the outputs
    function automatic ctrlWordT makeWord(input int pcW, irW, regW, aW, bW, aluOutW, shSrc,
                                          input int dst, srcA, srcB, op, mtr, shCtrl);
        ctrlWordT w;
        w.pcWrite     = pcW[0];
        w.irWrite     = irW[0];
        w.regWrite    = regW[0];
        w.aWrite      = aW[0];
        w.bWrite      = bW[0];
        w.aluOutWrite = aluOutW[0];
        w.shiftSrc    = shSrc[0];
        w.regDst      = dst[1:0];
        w.aluSrcA     = srcA[1:0];
        w.aluSrcB     = srcB[2:0];
        w.aluOp       = op[2:0];
        w.memToReg    = mtr[2:0];
        w.shiftCtrl   = shCtrl[2:0];
        return w;
    endfunction

    function automatic int pathLength(input int kind);
        if (kind == kindInvalid) begin
            return 6;
        end else if (kind >= kindSll && kind <= kindSra) begin
            return 10;
        end
        return 8;
    endfunction

    // Word of the state at a given step of the instruction's path
    function automatic ctrlWordT wordAt(input int kind, input int step);
        ctrlWordT w;
        w = '0;
        case (step)
            0: w = makeWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0);
            1: w = makeWord(1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0);
            2: w = makeWord(0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
            3: w = makeWord(0, 0, 0, 1, 1, 1, 0, 0, 0, 4, 1, 0, 0);
            4: w = makeWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
            5: begin
                if (kind <= kindAnd) begin
                    w = makeWord(0, 0, 0, 0, 0, 1, 0, 0, 1, 0, kind + 1, 0, 0);
                end else if (kind <= kindSra) begin
                    w = makeWord(0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1);
                end else if (kind == kindAddi) begin
                    w = makeWord(0, 0, 0, 0, 0, 1, 0, 0, 1, 3, 1, 0, 0);
                end
            end
            6: begin
                if (kind <= kindAnd) begin
                    w = makeWord(0, 0, 1, 0, 0, 0, 0, 3, 0, 0, 0, 0, 0);
                end else if (kind <= kindSra) begin
                    // Only sll keeps the shamt source selected
                    w = makeWord(0, 0, 0, 0, 0, 0, (kind == kindSll) ? 1 : 0,
                                 0, 0, 0, 0, 0, kind - 1);
                end else if (kind == kindAddi) begin
                    w = makeWord(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
                end
            end
            8: begin
                if (kind >= kindSll && kind <= kindSra) begin
                    w = makeWord(0, 0, 1, 0, 0, 0, 0, 3, 0, 0, 0, 2, 0);
                end
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    // Reference model stepping one path state per clock with outputs one cycle behind
    always @(posedge clk) begin
        if (reset) begin
            modelStep <= 0;
            expWord   <= '0;
        end else begin
            expWord <= wordAt(currentKind, modelStep);
            if (modelStep + 1 == pathLength(currentKind)) begin
                modelStep <= 0;
            end else begin
                modelStep <= modelStep + 1;
            end
        end
    end

    task automatic checkField(input string name, input logic [2:0] got, input logic [2:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic checkOutputs();
        checkField("pcWrite", 3'(pcWrite), 3'(expWord.pcWrite));
        checkField("irWrite", 3'(irWrite), 3'(expWord.irWrite));
        checkField("regWrite", 3'(regWrite), 3'(expWord.regWrite));
        checkField("aWrite", 3'(aWrite), 3'(expWord.aWrite));
        checkField("bWrite", 3'(bWrite), 3'(expWord.bWrite));
        checkField("aluOutWrite", 3'(aluOutWrite), 3'(expWord.aluOutWrite));
        checkField("shiftSrc", 3'(shiftSrc), 3'(expWord.shiftSrc));
        checkField("regDst", 3'(regDst), 3'(expWord.regDst));
        checkField("aluSrcA", 3'(aluSrcA), 3'(expWord.aluSrcA));
        checkField("aluSrcB", aluSrcB, expWord.aluSrcB);
        checkField("aluOp", aluOp, expWord.aluOp);
        checkField("memToReg", memToReg, expWord.memToReg);
        checkField("shiftCtrl", shiftCtrl, expWord.shiftCtrl);
    endtask

    // Plays the instruction register with about one unsupported encoding in ten
    task automatic driveInstruction();
        logic [31:0] r;
        r = nextRandom();
        if (r[31:24] < 8'd26) begin
            currentKind = kindInvalid;
        end else begin
            currentKind = int'(r[23:8] % 16'd7);
        end
        opcode = `OPC_RTYPE;
        funct  = r[5:0];
        case (currentKind)
            kindAdd:  funct = `FN_ADD;
            kindSub:  funct = `FN_SUB;
            kindAnd:  funct = `FN_AND;
            kindSll:  funct = `FN_SLL;
            kindSrl:  funct = `FN_SRL;
            kindSra:  funct = `FN_SRA;
            kindAddi: opcode = `OPC_ADDI;
            default: begin
                invalidCount++;
                if (r[6]) begin
                    // mult, div, jr, mfhi, mflo, slt, sllv, srav
                    case (r[9:7])
                        3'd0:    funct = 6'h18;
                        3'd1:    funct = 6'h1a;
                        3'd2:    funct = 6'h08;
                        3'd3:    funct = 6'h10;
                        3'd4:    funct = 6'h12;
                        3'd5:    funct = 6'h2a;
                        3'd6:    funct = 6'h04;
                        default: funct = 6'h07;
                    endcase
                end else begin
                    opcode = r[15:10];
                    if (opcode == `OPC_RTYPE || opcode == `OPC_ADDI) begin
                        opcode = opcode ^ 6'h21;
                    end
                end
            end
        endcase
    endtask

    // Fields are free to change once decode-wait has sampled them
    task automatic scrambleFields();
        logic [31:0] r;
        r = nextRandom();
        opcode = r[13:8];
        funct  = r[5:0];
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        randState     = 32'h04bf_b174;
        reset         = 1'b1;
        opcode        = `OPC_RTYPE;
        funct         = `FN_SLL;
        currentKind   = kindSll;
        valueErrors   = 0;
        lengthErrors  = 0;
        issued        = 0;
        invalidCount  = 0;
        cyclesSinceIr = 0;
        done          = 1'b0;
        repeat (16) begin
            @(negedge clk);
            checkOutputs();
        end
        reset = 1'b0;
        while (!done) begin
            @(negedge clk);
            checkOutputs();
            cyclesSinceIr++;
            if (irWrite) begin
                if (issued > 0) begin
                    assert (cyclesSinceIr == pathLength(currentKind)) else begin
                        lengthErrors++;
                        $display("Error at time %0t: instruction length expected %0d, got %0d",
                                 $time, pathLength(currentKind), cyclesSinceIr);
                    end
                end
                cyclesSinceIr = 0;
                if (issued == numInstr) begin
                    done = 1'b1;
                end else begin
                    driveInstruction();
                    issued++;
                end
            end else if (cyclesSinceIr == 2 && issued > 0) begin
                scrambleFields();
            end
        end
        $display("Instructions %0d, invalid %0d, value errors %0d, length errors %0d",
                 issued, invalidCount, valueErrors, lengthErrors);
        if (valueErrors + lengthErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+design
design/controlPkg.sv
design/instrDecoder.sv
design/stateSequencer.sv
design/controlEncoder.sv
design/controlUnit.sv
testbench/controlUnit_sva.sv
testbench/controlUnitTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = controlUnitTb
FILELIST = build.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
